// File: Bender.yml
package:
  name: lenet_addr_controller

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/lenet_addr_pkg.sv
      - src/layer_geometry_rom.sv
      - src/window_counter.sv
      - src/scan_fsm.sv
      - src/write_addr_gen.sv
      - src/lenet_addr_controller.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_lenet_addr_controller.sv

// File: include/lenet_addr_defines.svh
`ifndef LENET_ADDR_DEFINES_SVH
`define LENET_ADDR_DEFINES_SVH

// Datapath widths
`define ADDR_WIDTH  11
`define MODE_WIDTH  3

// Convolution kernel edge
`define KERNEL_SIZE 5

////////////////////////////////////////////////////////////////////////////
// Feature map edges per layer
////////////////////////////////////////////////////////////////////////////
`define MAP1_SIZE   32
`define MAP2_SIZE   28
`define MAP3_SIZE   14
`define MAP4_SIZE   10
`define MAP5_SIZE   5

////////////////////////////////////////////////////////////////////////////
// Read address a layer waits for before it scans
////////////////////////////////////////////////////////////////////////////
`define MAP1_START  172
`define MAP2_START  156
`define MAP3_START  100
`define MAP4_START  84
`define MAP5_START  59

// Both pooling layers start at the same point
`define POOL1_START 132
`define POOL2_START 132

`endif

// File: src/layer_geometry_rom.sv
`timescale 1ns/10ps

`include "lenet_addr_defines.svh"

module layer_geometry_rom
    import lenet_addr_pkg::*;
(
    input  layer_mode_t mode,
    output addr_t       map_size,
    output addr_t       start_addr,
    output scan_kind_t  kind
);

    always_comb begin
        case (mode)
            CONV1: begin
                map_size   = addr_t'(`MAP1_SIZE);
                start_addr = addr_t'(`MAP1_START);
                kind       = CONV;
            end
            CONV2: begin
                map_size   = addr_t'(`MAP2_SIZE);
                start_addr = addr_t'(`MAP2_START);
                kind       = CONV;
            end
            CONV3: begin
                map_size   = addr_t'(`MAP3_SIZE);
                start_addr = addr_t'(`MAP3_START);
                kind       = CONV;
            end
            CONV4: begin
                map_size   = addr_t'(`MAP4_SIZE);
                start_addr = addr_t'(`MAP4_START);
                kind       = CONV;
            end
            CONV5: begin
                map_size   = addr_t'(`MAP5_SIZE);
                start_addr = addr_t'(`MAP5_START);
                kind       = CONV;
            end
            // Pooling decimates the outputs of conv1 and conv3
            POOL1: begin
                map_size   = addr_t'(`MAP2_SIZE);
                start_addr = addr_t'(`POOL1_START);
                kind       = POOL;
            end
            POOL2: begin
                map_size   = addr_t'(`MAP4_SIZE);
                start_addr = addr_t'(`POOL2_START);
                kind       = POOL;
            end
            default: begin
                // All ones, above any address the host issues
                map_size   = addr_t'(`MAP5_SIZE);
                start_addr = '1;
                kind       = CONV;
            end
        endcase
    end

endmodule

// File: src/lenet_addr_controller.sv
`timescale 1ns/10ps

module lenet_addr_controller
    import lenet_addr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  layer_mode_t ctrl_mode,
    input  addr_t       ctrl_read_addr,
    output logic        valid_out,
    output addr_t       ctrl_write_addr
);

    addr_t      map_size;
    addr_t      start_addr;
    scan_kind_t kind;
    logic       col_inc;
    logic       col_clr;
    logic       edge_inc;
    logic       edge_clr;
    logic       row_inc;
    logic       cnt_clr;
    logic       col_last;
    logic       edge_last;
    logic       row_last;
    logic       odd_pos;

    ////////////////////////////////////////////////////////////////////////////
    // Layer lookup, scan control and counters
    ////////////////////////////////////////////////////////////////////////////
    layer_geometry_rom u_geometry (
        .mode       (ctrl_mode),
        .map_size   (map_size),
        .start_addr (start_addr),
        .kind       (kind)
    );

    scan_fsm u_scan_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .mode       (ctrl_mode),
        .read_addr  (ctrl_read_addr),
        .start_addr (start_addr),
        .kind       (kind),
        .col_last   (col_last),
        .edge_last  (edge_last),
        .row_last   (row_last),
        .odd_pos    (odd_pos),
        .col_inc    (col_inc),
        .col_clr    (col_clr),
        .edge_inc   (edge_inc),
        .edge_clr   (edge_clr),
        .row_inc    (row_inc),
        .cnt_clr    (cnt_clr),
        .valid      (valid_out)
    );

    window_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .map_size   (map_size),
        .kind       (kind),
        .col_inc    (col_inc),
        .col_clr    (col_clr),
        .edge_inc   (edge_inc),
        .edge_clr   (edge_clr),
        .row_inc    (row_inc),
        .cnt_clr    (cnt_clr),
        .col_last   (col_last),
        .edge_last  (edge_last),
        .row_last   (row_last),
        .odd_pos    (odd_pos)
    );

    // Output write pointer
    write_addr_gen u_write_addr (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .mode       (ctrl_mode),
        .valid      (valid_out),
        .write_addr (ctrl_write_addr)
    );

endmodule

// File: src/lenet_addr_pkg.sv
`include "lenet_addr_defines.svh"

package lenet_addr_pkg;

    // Address or counter value
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Layer selected by the host
    typedef enum logic [`MODE_WIDTH-1:0] {
        CONV1 = 3'd0,
        CONV2 = 3'd1,
        CONV3 = 3'd2,
        CONV4 = 3'd3,
        CONV5 = 3'd4,
        POOL1 = 3'd5,
        POOL2 = 3'd6,
        NONE  = 3'd7
    } layer_mode_t;

    // ACTIVE is the valid window for conv, the pixel fetch for pooling
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACTIVE = 2'd1,
        EDGE   = 2'd2,
        FINISH = 2'd3
    } scan_state_t;

    // How the map is walked
    typedef enum logic {
        CONV = 1'b0,
        POOL = 1'b1
    } scan_kind_t;

endpackage

// File: src/scan_fsm.sv
`timescale 1ns/10ps

module scan_fsm
    import lenet_addr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  layer_mode_t mode,
    input  addr_t       read_addr,
    input  addr_t       start_addr,
    input  scan_kind_t  kind,
    input  logic        col_last,
    input  logic        edge_last,
    input  logic        row_last,
    input  logic        odd_pos,
    output logic        col_inc,
    output logic        col_clr,
    output logic        edge_inc,
    output logic        edge_clr,
    output logic        row_inc,
    output logic        cnt_clr,
    output logic        valid
);

    addr_t       read_q;
    layer_mode_t mode_q;
    scan_state_t state_q;
    scan_state_t state_d;
    logic        valid_q;
    logic        valid_d;
    logic        clear;

    // Drop the scan when disabled or when the host picks another layer
    assign clear   = !en || (mode != mode_q);
    assign cnt_clr = clear;
    assign valid   = valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Next state and counter steps
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d  = state_q;
        valid_d  = 1'b0;
        col_inc  = 1'b0;
        col_clr  = 1'b0;
        edge_inc = 1'b0;
        edge_clr = 1'b0;
        row_inc  = 1'b0;
        case (state_q)
            IDLE: begin
                if (read_q >= start_addr) begin
                    state_d = ACTIVE;
                end
            end
            ACTIVE: begin
                if (kind == POOL) begin
                    // Only odd row and odd column close a 2x2 window
                    valid_d = odd_pos;
                    if (!col_last) begin
                        col_inc = 1'b1;
                    end else begin
                        col_clr = 1'b1;
                        if (!row_last) begin
                            row_inc = 1'b1;
                        end else begin
                            state_d = FINISH;
                        end
                    end
                end else begin
                    valid_d = 1'b1;
                    if (!col_last) begin
                        col_inc = 1'b1;
                    end else begin
                        col_clr  = 1'b1;
                        edge_clr = 1'b1;
                        state_d  = EDGE;
                    end
                end
            end
            EDGE: begin
                // Kernel overhang at the end of a row
                if (!edge_last) begin
                    edge_inc = 1'b1;
                end else begin
                    row_inc = 1'b1;
                    state_d = row_last ? FINISH : ACTIVE;
                end
            end
            default: begin
                state_d = FINISH;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_q  <= '0;
            mode_q  <= NONE;
            state_q <= IDLE;
            valid_q <= 1'b0;
        end else begin
            read_q <= read_addr;
            mode_q <= mode;
            if (clear) begin
                state_q <= IDLE;
                valid_q <= 1'b0;
            end else begin
                state_q <= state_d;
                valid_q <= valid_d;
            end
        end
    end

endmodule

// File: src/window_counter.sv
`timescale 1ns/10ps

`include "lenet_addr_defines.svh"

module window_counter
    import lenet_addr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  addr_t      map_size,
    input  scan_kind_t kind,
    input  logic       col_inc,
    input  logic       col_clr,
    input  logic       edge_inc,
    input  logic       edge_clr,
    input  logic       row_inc,
    input  logic       cnt_clr,
    output logic       col_last,
    output logic       edge_last,
    output logic       row_last,
    output logic       odd_pos
);

    addr_t row_cnt;
    addr_t col_cnt;
    addr_t edge_cnt;
    addr_t col_limit;
    addr_t row_limit;

    ////////////////////////////////////////////////////////////////////////////
    // Scan limits
    ////////////////////////////////////////////////////////////////////////////
    // Conv stops where the kernel still fits, pooling covers the whole map
    assign col_limit = (kind == POOL) ? map_size - addr_t'(1)
                                      : map_size - addr_t'(`KERNEL_SIZE);
    assign row_limit = col_limit;

    assign col_last  = (col_cnt >= col_limit);
    assign row_last  = (row_cnt >= row_limit);
    assign edge_last = (edge_cnt >= addr_t'(`KERNEL_SIZE - 2));
    assign odd_pos   = row_cnt[0] & col_cnt[0];

    ////////////////////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt  <= '0;
            col_cnt  <= '0;
            edge_cnt <= '0;
        end else if (cnt_clr) begin
            row_cnt  <= '0;
            col_cnt  <= '0;
            edge_cnt <= '0;
        end else begin
            if (col_clr) begin
                col_cnt <= '0;
            end else if (col_inc) begin
                col_cnt <= col_cnt + 1'b1;
            end
            if (edge_clr) begin
                edge_cnt <= '0;
            end else if (edge_inc) begin
                edge_cnt <= edge_cnt + 1'b1;
            end
            if (row_inc) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

endmodule

// File: src/write_addr_gen.sv
`timescale 1ns/10ps

module write_addr_gen
    import lenet_addr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  layer_mode_t mode,
    input  logic        valid,
    output addr_t       write_addr
);

    layer_mode_t mode_d1;
    layer_mode_t mode_d2;
    logic        mode_changed;

    // A mode change shows up two edges late
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_d1 <= NONE;
            mode_d2 <= NONE;
        end else begin
            mode_d1 <= mode;
            mode_d2 <= mode_d1;
        end
    end

    assign mode_changed = (mode_d1 != mode_d2);

    // One write slot per output pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_addr <= '0;
        end else if (en) begin
            if (mode_changed) begin
                write_addr <= '0;
            end else if (valid) begin
                write_addr <= write_addr + 1'b1;
            end
        end
    end

endmodule

// File: verif/tb_lenet_addr_controller.sv
`timescale 1ns/10ps

`include "lenet_addr_defines.svh"

module tb_lenet_addr_controller
    import lenet_addr_pkg::*;
();

    localparam int QUIET_CYCLES = 64;
    localparam int SCAN_LIMIT   = 3000;
    localparam int PAUSE_AT     = 100;

    logic        clk;
    logic        rst_n;
    logic        en;
    layer_mode_t ctrl_mode;
    addr_t       ctrl_read_addr;
    logic        valid_out;
    addr_t       ctrl_write_addr;

    int checks;
    int errors;
    bit trace[$];

    lenet_addr_controller uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .en              (en),
        .ctrl_mode       (ctrl_mode),
        .ctrl_read_addr  (ctrl_read_addr),
        .valid_out       (valid_out),
        .ctrl_write_addr (ctrl_write_addr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Expected values from the layer geometry
    ////////////////////////////////////////////////////////////////////////////
    // S x S windows where the 5x5 kernel fits
    function automatic int conv_pulses(input int map);
        int side;
        side = map - `KERNEL_SIZE + 1;
        return side * side;
    endfunction

    function automatic int pool_pulses(input int map);
        return (map / 2) * (map / 2);
    endfunction

    function automatic addr_t addr_above(input int start);
        return addr_t'(start + ($urandom % 200));
    endfunction

    function automatic int adjacent_pulses();
        int pairs;
        pairs = 0;
        for (int i = 1; i < trace.size(); i++) begin
            if (trace[i] && trace[i-1]) begin
                pairs++;
            end
        end
        return pairs;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and wait loops
    ////////////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic start_layer(input layer_mode_t mode, input addr_t addr);
        ctrl_mode      = mode;
        ctrl_read_addr = addr;
        en             = 1'b1;
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        int pulses;
        pulses = 0;
        repeat (cycles) begin
            next_cycle();
            if (valid_out) begin
                pulses++;
            end
        end
        check_count(name, 0, pulses);
    endtask

    task automatic wait_pulses(input string name, input int count, input int limit);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < count && cycles < limit) begin
            next_cycle();
            cycles++;
            if (valid_out) begin
                seen++;
            end
        end
        if (seen < count) begin
            errors++;
            $display("%s: only %0d valid pulses came within %0d cycles", name, seen, limit);
        end
    endtask

    // Records valid from the first pulse until the scan has gone quiet
    task automatic collect_scan(input string name, input int limit,
                                output int pulses, output addr_t first_addr);
        int cycles;
        int quiet;
        trace.delete();
        pulses = 0;
        quiet = 0;
        cycles = 0;
        first_addr = '0;
        while (!valid_out && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (!valid_out) begin
            errors++;
            $display("%s: no valid pulse came within %0d cycles", name, limit);
            return;
        end
        first_addr = ctrl_write_addr;
        while (quiet < QUIET_CYCLES && cycles < limit) begin
            if (valid_out) begin
                pulses++;
                quiet = 0;
            end else begin
                quiet++;
            end
            trace.push_back(valid_out);
            next_cycle();
            cycles++;
        end
        if (quiet < QUIET_CYCLES) begin
            errors++;
            $display("%s: the scan was still running after %0d cycles", name, limit);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_behavior();
        check_level("reset valid", 1'b0, valid_out);
        check_addr("reset write addr", '0, ctrl_write_addr);
        start_layer(NONE, addr_above(`MAP1_START));
        expect_quiet("mode none pulses", 200);
        check_addr("mode none write addr", '0, ctrl_write_addr);
    endtask

    task automatic run_conv(input string name, input layer_mode_t mode,
                            input int map, input int start);
        int pulses;
        addr_t first_addr;
        start_layer(mode, addr_above(start));
        collect_scan(name, SCAN_LIMIT, pulses, first_addr);
        check_addr({name, " first write addr"}, '0, first_addr);
        check_count({name, " pulses"}, conv_pulses(map), pulses);
        check_addr({name, " write addr"}, addr_t'(conv_pulses(map)), ctrl_write_addr);
    endtask

    // Every row is one run of valid followed by the kernel overhang
    task automatic conv_run_shape(input string name, input int run_len, input int gap_len);
        int run;
        int gap;
        int bad_runs;
        int bad_gaps;
        run = 0;
        gap = 0;
        bad_runs = 0;
        bad_gaps = 0;
        foreach (trace[i]) begin
            if (trace[i]) begin
                if (gap != 0 && gap != gap_len) begin
                    bad_gaps++;
                end
                gap = 0;
                run++;
            end else begin
                if (run != 0 && run != run_len) begin
                    bad_runs++;
                end
                run = 0;
                gap++;
            end
        end
        check_count({name, " runs of wrong length"}, 0, bad_runs);
        check_count({name, " gaps of wrong length"}, 0, bad_gaps);
    endtask

    task automatic conv_scans();
        run_conv("conv1", CONV1, `MAP1_SIZE, `MAP1_START);
        conv_run_shape("conv1", `MAP1_SIZE - `KERNEL_SIZE + 1, `KERNEL_SIZE - 1);
        run_conv("conv4", CONV4, `MAP4_SIZE, `MAP4_START);
        run_conv("conv5", CONV5, `MAP5_SIZE, `MAP5_START);
    endtask

    task automatic run_pool(input string name, input layer_mode_t mode,
                            input int map, input int start);
        int pulses;
        addr_t first_addr;
        start_layer(mode, addr_above(start));
        collect_scan(name, SCAN_LIMIT, pulses, first_addr);
        check_addr({name, " first write addr"}, '0, first_addr);
        check_count({name, " pulses"}, pool_pulses(map), pulses);
        check_count({name, " back to back pulses"}, 0, adjacent_pulses());
        check_addr({name, " write addr"}, addr_t'(pool_pulses(map)), ctrl_write_addr);
    endtask

    task automatic pool_scans();
        run_pool("pool1", POOL1, `MAP2_SIZE, `POOL1_START);
        run_pool("pool2", POOL2, `MAP4_SIZE, `POOL2_START);
    endtask

    task automatic threshold_start();
        int pulses;
        addr_t first_addr;
        start_layer(CONV2, addr_t'(`MAP2_START - 1));
        expect_quiet("conv2 below threshold", 200);
        ctrl_read_addr = addr_t'(`MAP2_START);
        collect_scan("conv2 at threshold", SCAN_LIMIT, pulses, first_addr);
        check_addr("conv2 first write addr", '0, first_addr);
        check_count("conv2 pulses", conv_pulses(`MAP2_SIZE), pulses);
        check_addr("conv2 write addr", addr_t'(conv_pulses(`MAP2_SIZE)), ctrl_write_addr);
    endtask

    // Write pointer clears two edges after the new mode
    task automatic mode_change_clear();
        int pulses;
        addr_t first_addr;
        start_layer(CONV4, addr_above(`MAP4_START));
        next_cycle();
        check_addr("write addr one edge after change",
                   addr_t'(conv_pulses(`MAP2_SIZE)), ctrl_write_addr);
        next_cycle();
        check_addr("write addr two edges after change", '0, ctrl_write_addr);
        collect_scan("conv4 after change", SCAN_LIMIT, pulses, first_addr);
        check_addr("write addr at first pulse", '0, first_addr);
        check_count("conv4 after change pulses", conv_pulses(`MAP4_SIZE), pulses);
    endtask

    task automatic enable_pause();
        int pulses;
        addr_t first_addr;
        start_layer(CONV1, addr_above(`MAP1_START));
        wait_pulses("conv1 before pause", PAUSE_AT, SCAN_LIMIT);
        en = 1'b0;
        check_addr("write addr at pause", addr_t'(PAUSE_AT - 1), ctrl_write_addr);
        repeat (20) next_cycle();
        check_addr("write addr while disabled", addr_t'(PAUSE_AT - 1), ctrl_write_addr);
        check_level("valid while disabled", 1'b0, valid_out);
        en = 1'b1;
        collect_scan("conv1 after pause", SCAN_LIMIT, pulses, first_addr);
        check_addr("write addr at restart", addr_t'(PAUSE_AT - 1), first_addr);
        check_count("conv1 restart pulses", conv_pulses(`MAP1_SIZE), pulses);
        check_addr("write addr after restart",
                   addr_t'(PAUSE_AT - 1 + conv_pulses(`MAP1_SIZE)), ctrl_write_addr);
    endtask

    initial begin
        checks = 0;
        errors = 0;
        rst_n = 1'b0;
        en = 1'b0;
        ctrl_mode = NONE;
        ctrl_read_addr = '0;
        void'($urandom(32'hc1fb_0636));
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        reset_behavior();
        conv_scans();
        pool_scans();
        threshold_start();
        mode_change_clear();
        enable_pause();

        $display("Run complete, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
src/lenet_addr_pkg.sv
src/layer_geometry_rom.sv
src/window_counter.sv
src/scan_fsm.sv
src/write_addr_gen.sv
src/lenet_addr_controller.sv
verif/tb_lenet_addr_controller.sv
